//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_surf_register_core
RTL_TOP   ?= surf_register_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_surf_register_core.sv
`timescale 1ns/10ps

module tb_surf_register_core;
    import rackbus_pkg::*;
    import regmap_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 8;
    localparam int ACK_LIMIT    = 16;
    localparam int DRAIN_LIMIT  = 200;
    localparam int FW_WORDS     = 4;
    // rough upper bound on the clock cycles of the whole directed sequence
    localparam int TEST_CYCLES  = 400;

    logic        wb_clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_w;
    logic        wb_ack;
    logic [31:0] wb_dat_r;
    logic        event_reset;
    logic [7:0]  disable_rxclk;
    logic        fw_tvalid;
    logic [7:0]  fw_tdata;
    logic        fw_tready;
    logic [1:0]  fw_mark;
    logic        fw_marked;
    logic        runcmd_tvalid;
    runcmd_t     runcmd_tdata;
    logic        runcmd_tready;
    logic        trig_tvalid;
    trig_t       trig_tdata;
    logic        trig_tready;

    integer      seed;
    int          errors;
    logic [31:0] fw_expected[$];

    // model of the control bits that the status word reflects
    logic        exp_fifo_reset;
    logic        exp_event_reset;
    logic [7:0]  exp_mask;

    surf_register_core #(
        .FW_DEPTH (FW_DEPTH_DEFAULT)
    ) u_dut (
        .wb_clk_i        (wb_clk),
        .reset_i         (reset),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_sel_i        (wb_sel),
        .wb_dat_i        (wb_dat_w),
        .wb_ack_o        (wb_ack),
        .wb_dat_o        (wb_dat_r),
        .event_reset_o   (event_reset),
        .disable_rxclk_o (disable_rxclk),
        .fw_tvalid_o     (fw_tvalid),
        .fw_tdata_o      (fw_tdata),
        .fw_tready_i     (fw_tready),
        .fw_mark_o       (fw_mark),
        .fw_marked_i     (fw_marked),
        .runcmd_tvalid_o (runcmd_tvalid),
        .runcmd_tdata_o  (runcmd_tdata),
        .runcmd_tready_i (runcmd_tready),
        .trig_tvalid_o   (trig_tvalid),
        .trig_tdata_o    (trig_tdata),
        .trig_tready_i   (trig_tready)
    );

    initial begin
        wb_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            wb_clk = ~wb_clk;
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD * 4);
        $display("timeout, the tests did not finish in time, %0d errors so far", errors);
        $display("Verification failed");
        $finish;
    end

    // every task starts and ends just after a rising edge
    task automatic next_cycle();
        @(posedge wb_clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mark(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_runcmd(input string name, input runcmd_t got, input runcmd_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_trig(input string name, input trig_t got, input trig_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_idle();
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_sel   = '0;
        wb_dat_w = '0;
    endtask

    task automatic wb_transfer(input logic we, input reg_addr_e adr, input logic [3:0] sel,
                               input logic [31:0] dat, output logic [31:0] rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_dat_w = dat;
        next_cycle();
        while (!wb_ack && waited < ACK_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            $display("no ack from the wishbone slave at address 0x%h", adr);
            errors++;
        end
        // the write lands on the edge that closes the ack cycle
        next_cycle();
        bus_idle();
        // one idle cycle so the late ack register drains
        next_cycle();
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [3:0] sel, input logic [31:0] dat);
        logic [31:0] unused;
        wb_transfer(1'b1, adr, sel, dat, unused);
    endtask

    task automatic wb_read(input reg_addr_e adr, output logic [31:0] rdata);
        wb_transfer(1'b0, adr, 4'hF, 32'h0, rdata);
    endtask

    task automatic check_status(input logic empty, input logic runcmd_busy,
                                input logic trig_busy, input logic [1:0] marks);
        logic [31:0] got;
        logic [31:0] exp;
        exp                                = '0;
        exp[CTRL_FIFO_RESET_BIT]           = exp_fifo_reset;
        exp[STAT_FW_EMPTY_BIT]             = empty;
        exp[STAT_RUNCMD_IDLE_BIT]          = !runcmd_busy;
        exp[STAT_TRIG_IDLE_BIT]            = !trig_busy;
        exp[CTRL_MARK_LSB +: 2]            = marks;
        exp[CTRL_EVENT_RESET_BIT]          = exp_event_reset;
        exp[CTRL_DISABLE_RXCLK_LSB +: 8]   = exp_mask;
        wb_read(CONTROL_ADDR, got);
        check_word("wb_dat_o", got, exp);
    endtask

    task automatic write_fw_word(input logic [31:0] word);
        wb_write(FWUPDATE_ADDR, 4'hF, word);
    endtask

    // accepts bytes with a random tready until every queued word has come out
    task automatic drain_fw_bytes();
        logic [31:0] rnd;
        logic [31:0] word;
        logic [7:0]  held_data;
        logic        held;
        int          n_bytes;
        int          got_bytes;
        int          byte_pos;
        int          cycles;
        n_bytes   = 4 * fw_expected.size();
        got_bytes = 0;
        byte_pos  = 0;
        cycles    = 0;
        held      = 1'b0;
        held_data = '0;
        word      = '0;
        while (got_bytes < n_bytes && cycles < DRAIN_LIMIT) begin
            if (held) begin
                check_bit("fw_tvalid_o held", fw_tvalid, 1'b1);
                check_byte("fw_tdata_o held", fw_tdata, held_data);
            end
            rnd       = $random(seed);
            fw_tready = rnd[0];
            if (fw_tvalid && fw_tready) begin
                if (byte_pos == 0) begin
                    word = fw_expected.pop_front();
                end
                check_byte("fw_tdata_o", fw_tdata, word[8*byte_pos +: 8]);
                byte_pos = (byte_pos + 1) % 4;
                got_bytes++;
                held = 1'b0;
            end else begin
                held      = fw_tvalid;
                held_data = fw_tdata;
            end
            next_cycle();
            cycles++;
        end
        fw_tready = 1'b0;
        if (got_bytes < n_bytes) begin
            $display("firmware stream stalled after %0d of %0d bytes", got_bytes, n_bytes);
            errors++;
            fw_expected.delete();
        end
    endtask

    task automatic expect_reset_state();
        logic [31:0] got;
        check_bit("fw_tvalid_o", fw_tvalid, 1'b0);
        check_bit("runcmd_tvalid_o", runcmd_tvalid, 1'b0);
        check_bit("trig_tvalid_o", trig_tvalid, 1'b0);
        check_mark("fw_mark_o", fw_mark, 2'b00);
        check_bit("event_reset_o", event_reset, 1'b0);
        check_byte("disable_rxclk_o", disable_rxclk, 8'hFF);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);
        // empty, both idle, mask all ones, whatever the address
        wb_read(TRIG_ADDR, got);
        check_word("wb_dat_o at TRIG_ADDR", got, 32'hFF00_000E);
    endtask

    task automatic exercise_control_lanes();
        wb_write(CONTROL_ADDR, 4'b1000, 32'h3CFF_FFFF);
        exp_mask = 8'h3C;
        check_byte("disable_rxclk_o", disable_rxclk, exp_mask);
        check_bit("event_reset_o", event_reset, exp_event_reset);
        check_mark("fw_mark_o", fw_mark, 2'b00);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);

        wb_write(CONTROL_ADDR, 4'b0100, 32'hFFFF_FFFF);
        exp_event_reset = 1'b1;
        check_bit("event_reset_o", event_reset, exp_event_reset);
        check_byte("disable_rxclk_o", disable_rxclk, exp_mask);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);

        wb_write(CONTROL_ADDR, 4'b1100, 32'hFF00_0000);
        exp_event_reset = 1'b0;
        exp_mask        = 8'hFF;
        check_bit("event_reset_o", event_reset, exp_event_reset);
        check_byte("disable_rxclk_o", disable_rxclk, exp_mask);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);
    endtask

    task automatic stream_fw_words();
        logic [31:0] word;
        fw_tready = 1'b0;
        for (int i = 0; i < FW_WORDS; i++) begin
            word = $random(seed);
            write_fw_word(word);
            fw_expected.push_back(word);
        end
        check_status(1'b0, 1'b0, 1'b0, 2'b00);
        drain_fw_bytes();
        next_cycle();
        check_bit("fw_tvalid_o", fw_tvalid, 1'b0);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);
    endtask

    task automatic flush_fw_fifo();
        logic [31:0] word;
        fw_tready = 1'b0;
        for (int i = 0; i < 2; i++) begin
            word = $random(seed);
            write_fw_word(word);
        end
        check_bit("fw_tvalid_o", fw_tvalid, 1'b1);
        check_status(1'b0, 1'b0, 1'b0, 2'b00);

        wb_write(CONTROL_ADDR, 4'b0001, 32'h0000_0001);
        exp_fifo_reset = 1'b1;
        check_bit("fw_tvalid_o", fw_tvalid, 1'b0);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);
        // dropped while the flush level is up
        word = $random(seed);
        write_fw_word(word);
        fw_tready = 1'b1;
        repeat (8) begin
            check_bit("fw_tvalid_o", fw_tvalid, 1'b0);
            next_cycle();
        end
        fw_tready = 1'b0;

        wb_write(CONTROL_ADDR, 4'b0001, 32'h0000_0000);
        exp_fifo_reset = 1'b0;
        check_status(1'b1, 1'b0, 1'b0, 2'b00);
        word = $random(seed);
        write_fw_word(word);
        fw_expected.push_back(word);
        drain_fw_bytes();
        check_status(1'b1, 1'b0, 1'b0, 2'b00);
    endtask

    task automatic hold_commands();
        logic [31:0] data;
        runcmd_t     exp_runcmd;
        trig_t       exp_trig;
        runcmd_tready = 1'b0;
        trig_tready   = 1'b0;

        data       = $random(seed);
        exp_runcmd = data[RUNCMD_BITS-1:0];
        wb_write(RUNCMD_ADDR, 4'b0001, data);
        repeat (3) begin
            check_bit("runcmd_tvalid_o", runcmd_tvalid, 1'b1);
            check_runcmd("runcmd_tdata_o", runcmd_tdata, exp_runcmd);
            next_cycle();
        end
        check_status(1'b1, 1'b1, 1'b0, 2'b00);
        runcmd_tready = 1'b1;
        next_cycle();
        runcmd_tready = 1'b0;
        check_bit("runcmd_tvalid_o", runcmd_tvalid, 1'b0);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);

        data     = $random(seed);
        exp_trig = data[TRIG_BITS-1:0];
        wb_write(TRIG_ADDR, 4'b0011, data);
        repeat (3) begin
            check_bit("trig_tvalid_o", trig_tvalid, 1'b1);
            check_trig("trig_tdata_o", trig_tdata, exp_trig);
            next_cycle();
        end
        check_status(1'b1, 1'b0, 1'b1, 2'b00);
        trig_tready = 1'b1;
        next_cycle();
        trig_tready = 1'b0;
        check_bit("trig_tvalid_o", trig_tvalid, 1'b0);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);
    endtask

    task automatic raise_and_clear_marks();
        wb_write(CONTROL_ADDR, 4'b0010, 32'h0000_0300);
        check_mark("fw_mark_o", fw_mark, 2'b11);
        check_status(1'b1, 1'b0, 1'b0, 2'b11);
        fw_marked = 1'b1;
        next_cycle();
        fw_marked = 1'b0;
        check_mark("fw_mark_o", fw_mark, 2'b00);
        check_status(1'b1, 1'b0, 1'b0, 2'b00);
    endtask

    initial begin
        errors          = 0;
        seed            = 32'h5a61;
        exp_fifo_reset  = 1'b0;
        exp_event_reset = 1'b0;
        exp_mask        = 8'hFF;
        reset           = 1'b1;
        fw_tready       = 1'b0;
        fw_marked       = 1'b0;
        runcmd_tready   = 1'b0;
        trig_tready     = 1'b0;
        bus_idle();

        repeat (RESET_CYCLES) @(posedge wb_clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        next_cycle();

        expect_reset_state();
        exercise_control_lanes();
        stream_fw_words();
        flush_fw_fifo();
        hold_commands();
        raise_and_clear_marks();

        $display("tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- files.f
rtl/rackbus_pkg.sv
rtl/regmap_pkg.sv
rtl/wb_reg_decode.sv
rtl/fw_byte_fifo.sv
rtl/cmd_holding.sv
rtl/surf_register_core.sv
dv/tb_surf_register_core.sv

//--- rtl/cmd_holding.sv
`timescale 1ns/10ps

module cmd_holding #(
    parameter int WIDTH = 8
) (
    input  logic             wb_clk_i,
    input  logic             reset_i,
    input  logic             load_i,
    input  logic [WIDTH-1:0] load_data_i,
    input  logic             tready_i,
    output logic             tvalid_o,
    output logic [WIDTH-1:0] tdata_o,
    output logic             busy_o
);

    // a load in the accept cycle keeps valid up with the new command
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            tvalid_o <= 1'b0;
        end else if (load_i) begin
            tvalid_o <= 1'b1;
        end else if (tvalid_o && tready_i) begin
            tvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (load_i) begin
            tdata_o <= load_data_i;
        end
    end

    // status reports idle once the command is taken
    assign busy_o = tvalid_o;

    a_valid_until_ready : assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        $fell(tvalid_o) |-> $past(tready_i)
    );

endmodule

//--- rtl/fw_byte_fifo.sv
`timescale 1ns/10ps

module fw_byte_fifo #(
    parameter int DEPTH = rackbus_pkg::FW_DEPTH_DEFAULT
) (
    input  logic                wb_clk_i,
    input  logic                reset_i,
    input  regmap_pkg::reg_wr_t wr_i,
    input  logic                fw_tready_i,
    input  logic                fw_marked_i,
    output logic                fw_tvalid_o,
    output logic [7:0]          fw_tdata_o,
    output logic                fw_empty_o,
    output logic [1:0]          fw_mark_o
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(DEPTH - 1);
    localparam logic [PTR_BITS:0]   FULL_COUNT = (PTR_BITS + 1)'(DEPTH);

    typedef enum logic {
        FW_IDLE,
        FW_SHIFT
    } fw_state_e;

    logic [31:0]         mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                push;
    logic                pop;
    logic                shift;
    fw_state_e           state;
    logic [31:0]         shift_word;
    logic [1:0]          byte_idx;

    // full FIFO drops the write, flush blocks both sides
    assign push  = wr_i.fw_wr && !wr_i.fw_flush && (count != FULL_COUNT);
    assign pop   = (state == FW_IDLE) && (count != '0) && !wr_i.fw_flush;
    assign shift = (state == FW_SHIFT) && fw_tready_i;

    always_ff @(posedge wb_clk_i) begin
        if (push) begin
            mem[wr_ptr] <= wr_i.data;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i || wr_i.fw_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // serializer, one word at a time, byte 0 first
    always_ff @(posedge wb_clk_i) begin
        if (reset_i || wr_i.fw_flush) begin
            state    <= FW_IDLE;
            byte_idx <= '0;
        end else begin
            case (state)
                FW_IDLE: begin
                    if (pop) begin
                        state    <= FW_SHIFT;
                        byte_idx <= '0;
                    end
                end
                FW_SHIFT: begin
                    if (fw_tready_i) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == 2'd3) begin
                            state <= FW_IDLE;
                        end
                    end
                end
                default: state <= FW_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (pop) begin
            shift_word <= mem[rd_ptr];
        end else if (shift) begin
            shift_word <= {8'h00, shift_word[31:8]};
        end
    end

    assign fw_tvalid_o = (state == FW_SHIFT);
    assign fw_tdata_o  = shift_word[7:0];
    assign fw_empty_o  = (count == '0) && (state == FW_IDLE);

    // a new request beats a clear in the same cycle
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            fw_mark_o <= '0;
        end else begin
            fw_mark_o <= wr_i.mark_set | (fw_mark_o & ~{2{fw_marked_i}});
        end
    end

    a_tdata_hold : assert property (
        @(posedge wb_clk_i) disable iff (reset_i || wr_i.fw_flush)
        fw_tvalid_o && !fw_tready_i |=> fw_tvalid_o && $stable(fw_tdata_o)
    );

endmodule

//--- rtl/rackbus_pkg.sv
package rackbus_pkg;

    // run command field, only the low bits of the register carry it
    localparam int RUNCMD_BITS = 2;

    // trigger field width
    localparam int TRIG_BITS = 15;

    // payload types for the two command streams
    typedef logic [RUNCMD_BITS-1:0] runcmd_t;
    typedef logic [TRIG_BITS-1:0]   trig_t;

    // firmware FIFO depth in 32-bit words
    // a full image is written in small bursts and polled for empty in between
    localparam int FW_DEPTH_DEFAULT = 16;

endpackage

//--- rtl/regmap_pkg.sv
package regmap_pkg;

    localparam int ADDR_BITS = 5;

    // byte addresses of the four registers
    typedef enum logic [ADDR_BITS-1:0] {
        CONTROL_ADDR  = 5'h00,
        FWUPDATE_ADDR = 5'h04,
        RUNCMD_ADDR   = 5'h08,
        TRIG_ADDR     = 5'h0C
    } reg_addr_e;

    // control and status word bit positions
    localparam int CTRL_FIFO_RESET_BIT    = 0;
    localparam int STAT_FW_EMPTY_BIT      = 1;
    localparam int STAT_RUNCMD_IDLE_BIT   = 2;
    localparam int STAT_TRIG_IDLE_BIT     = 3;
    // two bits, write one to set a mark, reads back as pending
    localparam int CTRL_MARK_LSB          = 8;
    localparam int CTRL_EVENT_RESET_BIT   = 16;
    // eight bit mask in the top byte
    localparam int CTRL_DISABLE_RXCLK_LSB = 24;

    // receive clocks start out disabled
    localparam logic [7:0] DISABLE_RXCLK_RESET = 8'hFF;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [ADDR_BITS-1:0] adr;
        logic [3:0]           sel;
        logic [31:0]          dat;
    } wb_req_t;

    // strobes are one cycle wide in the ack cycle, fw_flush is a level
    typedef struct packed {
        logic        fw_wr;
        logic        fw_flush;
        logic        runcmd_wr;
        logic        trig_wr;
        logic [1:0]  mark_set;
        logic [31:0] data;
    } reg_wr_t;

endpackage

//--- rtl/surf_register_core.sv
`timescale 1ns/10ps

module surf_register_core #(
    parameter int FW_DEPTH = rackbus_pkg::FW_DEPTH_DEFAULT
) (
    input  logic                 wb_clk_i,
    input  logic                 reset_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [4:0]           wb_adr_i,
    input  logic [3:0]           wb_sel_i,
    input  logic [31:0]          wb_dat_i,
    output logic                 wb_ack_o,
    output logic [31:0]          wb_dat_o,
    output logic                 event_reset_o,
    output logic [7:0]           disable_rxclk_o,
    output logic                 fw_tvalid_o,
    output logic [7:0]           fw_tdata_o,
    input  logic                 fw_tready_i,
    output logic [1:0]           fw_mark_o,
    input  logic                 fw_marked_i,
    output logic                 runcmd_tvalid_o,
    output rackbus_pkg::runcmd_t runcmd_tdata_o,
    input  logic                 runcmd_tready_i,
    output logic                 trig_tvalid_o,
    output rackbus_pkg::trig_t   trig_tdata_o,
    input  logic                 trig_tready_i
);
    import rackbus_pkg::*;
    import regmap_pkg::*;

    wb_req_t wb_req;
    reg_wr_t wr;
    logic    fw_empty;
    logic    runcmd_busy;
    logic    trig_busy;

    always_comb begin
        wb_req.cyc = wb_cyc_i;
        wb_req.stb = wb_stb_i;
        wb_req.we  = wb_we_i;
        wb_req.adr = wb_adr_i;
        wb_req.sel = wb_sel_i;
        wb_req.dat = wb_dat_i;
    end

    wb_reg_decode u_decode (
        .wb_clk_i        (wb_clk_i),
        .reset_i         (reset_i),
        .wb_req_i        (wb_req),
        .fw_empty_i      (fw_empty),
        .mark_pending_i  (fw_mark_o),
        .runcmd_busy_i   (runcmd_busy),
        .trig_busy_i     (trig_busy),
        .wb_ack_o        (wb_ack_o),
        .wb_dat_o        (wb_dat_o),
        .wr_o            (wr),
        .event_reset_o   (event_reset_o),
        .disable_rxclk_o (disable_rxclk_o)
    );

    fw_byte_fifo #(
        .DEPTH (FW_DEPTH)
    ) u_fw_fifo (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .wr_i        (wr),
        .fw_tready_i (fw_tready_i),
        .fw_marked_i (fw_marked_i),
        .fw_tvalid_o (fw_tvalid_o),
        .fw_tdata_o  (fw_tdata_o),
        .fw_empty_o  (fw_empty),
        .fw_mark_o   (fw_mark_o)
    );

    // both commands sit in the low bits of the written word
    cmd_holding #(
        .WIDTH (RUNCMD_BITS)
    ) u_runcmd (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .load_i      (wr.runcmd_wr),
        .load_data_i (wr.data[RUNCMD_BITS-1:0]),
        .tready_i    (runcmd_tready_i),
        .tvalid_o    (runcmd_tvalid_o),
        .tdata_o     (runcmd_tdata_o),
        .busy_o      (runcmd_busy)
    );

    cmd_holding #(
        .WIDTH (TRIG_BITS)
    ) u_trig (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .load_i      (wr.trig_wr),
        .load_data_i (wr.data[TRIG_BITS-1:0]),
        .tready_i    (trig_tready_i),
        .tvalid_o    (trig_tvalid_o),
        .tdata_o     (trig_tdata_o),
        .busy_o      (trig_busy)
    );

endmodule

//--- rtl/wb_reg_decode.sv
`timescale 1ns/10ps

module wb_reg_decode (
    input  logic                wb_clk_i,
    input  logic                reset_i,
    input  regmap_pkg::wb_req_t wb_req_i,
    input  logic                fw_empty_i,
    input  logic [1:0]          mark_pending_i,
    input  logic                runcmd_busy_i,
    input  logic                trig_busy_i,
    output logic                wb_ack_o,
    output logic [31:0]         wb_dat_o,
    output regmap_pkg::reg_wr_t wr_o,
    output logic                event_reset_o,
    output logic [7:0]          disable_rxclk_o
);
    import regmap_pkg::*;

    logic      ack;
    logic      fifo_reset;
    logic      wr_cycle;
    logic      ctrl_wr;
    reg_addr_e addr;

    // single wait state, ack is just the request one cycle late
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack <= 1'b0;
        end else begin
            ack <= wb_req_i.cyc && wb_req_i.stb;
        end
    end

    assign wb_ack_o = ack && wb_req_i.cyc;

    assign addr     = reg_addr_e'(wb_req_i.adr);
    // writes only land in the ack cycle
    assign wr_cycle = wb_ack_o && wb_req_i.stb && wb_req_i.we;
    assign ctrl_wr  = wr_cycle && (addr == CONTROL_ADDR);

    always_comb begin
        wr_o           = '0;
        wr_o.fw_wr     = wr_cycle && (addr == FWUPDATE_ADDR);
        wr_o.runcmd_wr = wr_cycle && (addr == RUNCMD_ADDR) && wb_req_i.sel[0];
        // trigger is 15 bits so it needs both low lanes
        wr_o.trig_wr   = wr_cycle && (addr == TRIG_ADDR) &&
                         wb_req_i.sel[0] && wb_req_i.sel[1];
        if (ctrl_wr && wb_req_i.sel[1]) begin
            wr_o.mark_set = wb_req_i.dat[CTRL_MARK_LSB +: 2];
        end
        wr_o.fw_flush  = fifo_reset;
        wr_o.data      = wb_req_i.dat;
    end

    // control bits, each byte lane independent
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            fifo_reset      <= 1'b0;
            event_reset_o   <= 1'b0;
            disable_rxclk_o <= DISABLE_RXCLK_RESET;
        end else if (ctrl_wr) begin
            if (wb_req_i.sel[0]) begin
                fifo_reset <= wb_req_i.dat[CTRL_FIFO_RESET_BIT];
            end
            if (wb_req_i.sel[2]) begin
                event_reset_o <= wb_req_i.dat[CTRL_EVENT_RESET_BIT];
            end
            if (wb_req_i.sel[3]) begin
                disable_rxclk_o <= wb_req_i.dat[CTRL_DISABLE_RXCLK_LSB +: 8];
            end
        end
    end

    // every address reads back the same status word
    always_comb begin
        wb_dat_o                               = '0;
        wb_dat_o[CTRL_FIFO_RESET_BIT]          = fifo_reset;
        wb_dat_o[STAT_FW_EMPTY_BIT]            = fw_empty_i;
        wb_dat_o[STAT_RUNCMD_IDLE_BIT]         = !runcmd_busy_i;
        wb_dat_o[STAT_TRIG_IDLE_BIT]           = !trig_busy_i;
        wb_dat_o[CTRL_MARK_LSB +: 2]           = mark_pending_i;
        wb_dat_o[CTRL_EVENT_RESET_BIT]         = event_reset_o;
        wb_dat_o[CTRL_DISABLE_RXCLK_LSB +: 8]  = disable_rxclk_o;
    end

    // ack only while the master still holds its request
    a_ack_with_req : assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        wb_ack_o |-> wb_req_i.cyc && wb_req_i.stb
    );

endmodule
